// File: logic/apbRegPkg.sv
// APB register map of the I2C master with addresses and configuration field layout
`default_nettype none

package apbRegPkg;

	////////////////////
	// Word addresses
	////////////////////

	// Push into the transmit FIFO
	localparam logic [31:0] regAddrTx = 32'd0;
	// Pop from the receive FIFO
	localparam logic [31:0] regAddrRx = 32'd4;
	// Configuration word, reads back
	localparam logic [31:0] regAddrConfig = 32'd8;
	// SCL half-period in PCLK cycles
	localparam logic [31:0] regAddrClkDiv = 32'd12;
	// Filled receive slots
	localparam logic [31:0] regAddrRxCredits = 32'd16;

	////////////////////
	// Register layout
	////////////////////

	// Width of the configuration and divider registers
	localparam int cfgWidth = 14;

	// Field positions inside the configuration word
	localparam int cfgStartBit = 0;
	localparam int cfgReadBit = 1;
	localparam int cfgAddrLsb = 2;
	localparam int cfgCountLsb = 9;

endpackage

`default_nettype wire

// File: logic/i2cBusPkg.sv
// I2C bus types and bus-level constants shared by the FIFOs and the bit engine
`default_nettype none

package i2cBusPkg;

	// Bits in one bus byte
	localparam int i2cByteBits = 8;

	// Data byte on the bus and in the FIFOs
	typedef logic [i2cByteBits-1:0] i2cByteT;
	// Number of data bytes in one transaction, 1 to 31
	typedef logic [4:0] i2cCountT;
	// 7-bit target address
	typedef logic [6:0] i2cAddrT;

	// Shortest allowed SCL half-period in PCLK cycles
	localparam int i2cMinHalf = 2;
	// Released SDA during the acknowledge bit means NACK
	localparam logic i2cNack = 1'b1;

endpackage

`default_nettype wire

// File: logic/byteFifo.sv
// Synchronous byte FIFO on a circular buffer, used for transmit and receive
`default_nettype none
`timescale 1ns/1ps

module byteFifo #(
	parameter int fifoDepth = 4
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic push,
	input  i2cBusPkg::i2cByteT pushData,
	input  logic pop,
	output i2cBusPkg::i2cByteT headData,
	output logic [$clog2(fifoDepth+1)-1:0] count,
	output logic empty
);
	import i2cBusPkg::*;

	localparam int ptrW = $clog2(fifoDepth);
	localparam int cntW = $clog2(fifoDepth + 1);
	localparam logic [cntW-1:0] fullCount = cntW'(fifoDepth);
	localparam logic [ptrW-1:0] lastPtr = ptrW'(fifoDepth - 1);

	i2cByteT mem [fifoDepth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic doPop;

	assign empty = (count == '0);
	// Pops on an empty FIFO are dropped
	assign doPop = pop && !empty;
	// Head reads zero when nothing is stored
	assign headData = empty ? '0 : mem[rdPtr];

	// Storage array
	always_ff @(posedge PCLK)
	begin
		if (push)
		begin
			mem[wrPtr] <= pushData;
		end
	end

	// Pointers wrap at the depth, which need not be a power of two
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
			end
			count <= count + cntW'(push) - cntW'(doPop);
		end
	end

	// Writers hold off on their own when full, by credits or by rxCount
	assert property (@(posedge PCLK) disable iff (!PRESETn) count == fullCount |-> !push);

endmodule

`default_nettype wire

// File: logic/apbSlave.sv
// APB slave of the I2C master with register decode, transmit credits and read mux
`default_nettype none
`timescale 1ns/1ps

module apbSlave #(
	parameter int fifoDepth = 4
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [31:0] pAddr,
	input  logic [31:0] pWdata,
	input  i2cBusPkg::i2cByteT rxHead,
	input  logic [$clog2(fifoDepth+1)-1:0] rxCount,
	input  logic txEmpty,
	input  logic rxEmpty,
	input  logic txPop,
	input  logic xferDone,
	input  logic nackSeen,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlvErr,
	output logic txPush,
	output i2cBusPkg::i2cByteT txData,
	output logic rxPop,
	output logic [apbRegPkg::cfgWidth-1:0] cfgWord,
	output logic [apbRegPkg::cfgWidth-1:0] clkDiv,
	output logic intTx,
	output logic intRx
);
	import apbRegPkg::*;
	import i2cBusPkg::*;

	localparam int cntW = $clog2(fifoDepth + 1);
	localparam logic [cntW-1:0] creditMax = cntW'(fifoDepth);

	logic accessPhase;
	logic txAccess;
	logic cfgWrite;
	logic divWrite;
	logic creditAvail;
	logic [cntW-1:0] txCredits;
	i2cCountT newCount;

	////////////////////
	// Address decode
	////////////////////

	assign accessPhase = pSel && pEnable;
	assign txAccess = accessPhase && pWrite && (pAddr == regAddrTx);
	assign rxPop = accessPhase && !pWrite && (pAddr == regAddrRx);
	assign cfgWrite = accessPhase && pWrite && (pAddr == regAddrConfig);
	assign divWrite = accessPhase && pWrite && (pAddr == regAddrClkDiv);

	// Push only with a free slot and hold the access otherwise
	assign creditAvail = (txCredits != '0);
	assign txPush = txAccess && creditAvail;
	assign txData = pWdata[$bits(i2cByteT)-1:0];
	assign pReady = accessPhase && (!txAccess || creditAvail);

	// Sticky NACK shows up on every access
	assign pSlvErr = accessPhase && nackSeen;
	// Level interrupts
	assign intTx = txEmpty;
	assign intRx = !rxEmpty;

	// Byte count field of the incoming configuration word
	assign newCount = pWdata[cfgCountLsb +: $bits(i2cCountT)];

	// Configuration and divider registers
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgWord <= '0;
			clkDiv <= '0;
		end
		else
		begin
			if (cfgWrite)
			begin
				cfgWord <= pWdata[cfgWidth-1:0];
				// A zero-length transfer never starts
				cfgWord[cfgStartBit] <= pWdata[cfgStartBit] && (newCount != '0);
			end
			else if (xferDone)
			begin
				cfgWord[cfgStartBit] <= 1'b0;
			end
			if (divWrite)
			begin
				clkDiv <= pWdata[cfgWidth-1:0];
			end
		end
	end

	// Credits track free transmit slots and each master pop hands one back
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			txCredits <= creditMax;
		end
		else
		begin
			txCredits <= txCredits - cntW'(txPush) + cntW'(txPop);
		end
	end

	// Read data stays zero outside a read access
	always_comb
	begin
		pRdata = '0;
		if (accessPhase && !pWrite)
		begin
			case (pAddr)
				regAddrRx: pRdata = 32'(rxHead);
				regAddrConfig: pRdata = 32'(cfgWord);
				regAddrClkDiv: pRdata = 32'(clkDiv);
				regAddrRxCredits: pRdata = 32'(rxCount);
				default: pRdata = '0;
			endcase
		end
	end

	// Pops from the master never push the credits past the FIFO size
	assert property (@(posedge PCLK) disable iff (!PRESETn) txCredits <= creditMax);
	// Every credit is free exactly when the transmit FIFO is empty
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(txCredits == creditMax) == txEmpty);

endmodule

`default_nettype wire

// File: logic/i2cMaster.sv
// I2C bit engine running one START, address, data and STOP transaction per start bit
`default_nettype none
`timescale 1ns/1ps

module i2cMaster #(
	parameter int fifoDepth = 4
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic [apbRegPkg::cfgWidth-1:0] cfgWord,
	input  logic [apbRegPkg::cfgWidth-1:0] clkDiv,
	input  i2cBusPkg::i2cByteT txHead,
	input  logic txEmpty,
	input  logic [$clog2(fifoDepth+1)-1:0] rxCount,
	input  logic sdaIn,
	output logic txPop,
	output logic rxPush,
	output i2cBusPkg::i2cByteT rxData,
	output logic scl,
	output logic sdaOe,
	output logic xferDone,
	output logic nackSeen
);
	import apbRegPkg::*;
	import i2cBusPkg::*;

	localparam int cntW = $clog2(fifoDepth + 1);
	localparam logic [cntW-1:0] rxFull = cntW'(fifoDepth);
	localparam logic [cfgWidth-1:0] halfMin = cfgWidth'(i2cMinHalf);
	localparam logic [2:0] lastBit = 3'(i2cByteBits - 1);

	// FSM encoding
	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stStart = 3'd1;
	localparam logic [2:0] stAddr = 3'd2;
	localparam logic [2:0] stAck = 3'd3;
	localparam logic [2:0] stData = 3'd4;
	localparam logic [2:0] stMack = 3'd5;
	localparam logic [2:0] stStop = 3'd6;

	logic [2:0] state;
	logic [cfgWidth-1:0] halfPeriod;
	logic [cfgWidth-1:0] phaseCnt;
	logic tick;
	logic holdPhase;
	logic launch;
	logic writeBits;
	logic [2:0] bitIdx;
	i2cByteT shReg;
	i2cCountT bytesLeft;
	i2cAddrT targetAddr;
	logic isRead;
	logic byteReady;
	logic sdaDrive;

	// Divider below the minimum runs at the minimum
	assign halfPeriod = (clkDiv < halfMin) ? halfMin : clkDiv;
	assign tick = (phaseCnt == '0);
	// Counter stays loaded while idle or waiting on a FIFO
	assign holdPhase = (state == stIdle) || (state == stData && !byteReady);
	// xferDone blocks a relaunch before the start bit is cleared
	assign launch = (state == stIdle) && cfgWord[cfgStartBit] && !xferDone;
	assign writeBits = (state == stAddr) || !isRead;
	assign targetAddr = cfgWord[cfgAddrLsb +: $bits(i2cAddrT)];

	////////////////////
	// Phase timing
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			phaseCnt <= '0;
		end
		else if (tick || holdPhase)
		begin
			phaseCnt <= halfPeriod - 1'b1;
		end
		else
		begin
			phaseCnt <= phaseCnt - 1'b1;
		end
	end

	// SDA lands one cycle after the FSM decides, so never on the SCL edge itself
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			sdaOe <= 1'b0;
		end
		else
		begin
			sdaOe <= sdaDrive;
		end
	end

	////////////////////
	// Transaction FSM
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= stIdle;
			scl <= 1'b1;
			sdaDrive <= 1'b0;
			bitIdx <= '0;
			bytesLeft <= '0;
			isRead <= 1'b0;
			byteReady <= 1'b0;
			nackSeen <= 1'b0;
			xferDone <= 1'b0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
		end
		else
		begin
			txPop <= 1'b0;
			rxPush <= 1'b0;
			xferDone <= 1'b0;
			case (state)
				stIdle:
				begin
					// START pulls SDA low while SCL stays high
					if (launch)
					begin
						state <= stStart;
						sdaDrive <= 1'b1;
						shReg <= {targetAddr, cfgWord[cfgReadBit]};
						isRead <= cfgWord[cfgReadBit];
						bytesLeft <= cfgWord[cfgCountLsb +: $bits(i2cCountT)];
						nackSeen <= 1'b0;
					end
				end
				stStart:
				begin
					if (tick)
					begin
						scl <= 1'b0;
						state <= stAddr;
						bitIdx <= lastBit;
						sdaDrive <= !shReg[i2cByteBits-1];
					end
				end
				stAddr, stData:
				begin
					if (state == stData && !byteReady)
					begin
						// SCL held low until a byte is there to send or room to receive
						if (!isRead && !txEmpty)
						begin
							txPop <= 1'b1;
							shReg <= txHead;
							sdaDrive <= !txHead[i2cByteBits-1];
							byteReady <= 1'b1;
							bytesLeft <= bytesLeft - 1'b1;
						end
						else if (isRead && rxCount < rxFull)
						begin
							sdaDrive <= 1'b0;
							byteReady <= 1'b1;
							bytesLeft <= bytesLeft - 1'b1;
						end
					end
					else if (tick && !scl)
					begin
						scl <= 1'b1;
					end
					else if (tick)
					begin
						// End of high phase, sample and shift MSB first
						scl <= 1'b0;
						shReg <= {shReg[i2cByteBits-2:0], sdaIn};
						if (bitIdx != '0)
						begin
							bitIdx <= bitIdx - 1'b1;
							sdaDrive <= writeBits && !shReg[i2cByteBits-2];
						end
						else if (writeBits)
						begin
							byteReady <= 1'b0;
							state <= stAck;
							sdaDrive <= 1'b0;
						end
						else
						begin
							byteReady <= 1'b0;
							state <= stMack;
							rxData <= {shReg[i2cByteBits-2:0], sdaIn};
							rxPush <= 1'b1;
							// ACK unless this was the last byte
							sdaDrive <= (bytesLeft != '0);
						end
					end
				end
				stAck, stMack:
				begin
					if (tick && !scl)
					begin
						scl <= 1'b1;
					end
					else if (tick)
					begin
						scl <= 1'b0;
						// Target NACK counts only in the target ack slot
						if (state == stAck && sdaIn == i2cNack)
						begin
							nackSeen <= 1'b1;
						end
						if ((state == stAck && sdaIn == i2cNack) || bytesLeft == '0)
						begin
							state <= stStop;
							sdaDrive <= 1'b1;
							bitIdx <= 3'd1;
						end
						else
						begin
							state <= stData;
							bitIdx <= lastBit;
							sdaDrive <= 1'b0;
						end
					end
				end
				stStop:
				begin
					// SCL rises, then SDA rises, then one idle half-period
					if (tick && !scl)
					begin
						scl <= 1'b1;
					end
					else if (tick && bitIdx != '0)
					begin
						sdaDrive <= 1'b0;
						bitIdx <= '0;
					end
					else if (tick)
					begin
						state <= stIdle;
						xferDone <= 1'b1;
					end
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

	// Data changes only with SCL low, START and STOP excepted
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		$changed(sdaOe) |-> !scl || state == stStart || state == stStop);

endmodule

`default_nettype wire

// File: logic/apbI2cTop.sv
// APB to I2C master top level joining the slave, both FIFOs and the bit engine
`default_nettype none
`timescale 1ns/1ps

module apbI2cTop #(
	parameter int fifoDepth = 4
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [31:0] pAddr,
	input  logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlvErr,
	output logic scl,
	output logic sdaOe,
	input  logic sdaIn,
	output logic intTx,
	output logic intRx
);
	import apbRegPkg::*;
	import i2cBusPkg::*;

	localparam int cntW = $clog2(fifoDepth + 1);

	// Transmit path
	logic txPush;
	i2cByteT txData;
	logic txPop;
	i2cByteT txHead;
	logic txEmpty;

	// Receive path
	logic rxPush;
	i2cByteT rxData;
	logic rxPop;
	i2cByteT rxHead;
	logic [cntW-1:0] rxCount;
	logic rxEmpty;

	// Control between slave and bit engine
	logic [cfgWidth-1:0] cfgWord;
	logic [cfgWidth-1:0] clkDiv;
	logic xferDone;
	logic nackSeen;

	apbSlave #(.fifoDepth(fifoDepth)) i_apbSlave (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata),
		.rxHead(rxHead), .rxCount(rxCount),
		.txEmpty(txEmpty), .rxEmpty(rxEmpty), .txPop(txPop),
		.xferDone(xferDone), .nackSeen(nackSeen),
		.pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr),
		.txPush(txPush), .txData(txData), .rxPop(rxPop),
		.cfgWord(cfgWord), .clkDiv(clkDiv),
		.intTx(intTx), .intRx(intRx)
	);

	// Transmit fill level is tracked by the credits, so count stays open
	byteFifo #(.fifoDepth(fifoDepth)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pushData(txData), .pop(txPop),
		.headData(txHead), .count(), .empty(txEmpty)
	);

	byteFifo #(.fifoDepth(fifoDepth)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pushData(rxData), .pop(rxPop),
		.headData(rxHead), .count(rxCount), .empty(rxEmpty)
	);

	i2cMaster #(.fifoDepth(fifoDepth)) i_i2cMaster (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.cfgWord(cfgWord), .clkDiv(clkDiv),
		.txHead(txHead), .txEmpty(txEmpty), .rxCount(rxCount),
		.sdaIn(sdaIn),
		.txPop(txPop), .rxPush(rxPush), .rxData(rxData),
		.scl(scl), .sdaOe(sdaOe),
		.xferDone(xferDone), .nackSeen(nackSeen)
	);

endmodule

`default_nettype wire

// File: verification/i2cTargetModel.sv
// Behavioral I2C target with wired-AND SDA, one fixed address, write capture and read replies
`default_nettype none
`timescale 1ns/1ps

module i2cTargetModel #(
	parameter logic [6:0] ownAddr = 7'h2A
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic scl,
	input  logic masterPull,
	output logic sda
);
	logic sclPrev;
	logic sdaPrev;
	logic pull;
	logic active;
	logic addrPhase;
	logic selected;
	logic readMode;
	logic masterAcked;
	logic [3:0] bitCnt;
	logic [7:0] shiftIn;
	logic [7:0] shiftOut;
	logic [7:0] readIdx;
	logic [7:0] replyByte;
	// Written bytes in arrival order, kept across transactions
	logic [7:0] capData [$];
	int capCount;

	// Open-drain line, low when either side pulls
	assign sda = !(masterPull || pull);
	// Read reply is 0xA0 plus the byte index inside the transaction
	assign replyByte = 8'hA0 + readIdx;

	// Bus sampled on PCLK, edges found against the previous sample
	always @(posedge PCLK)
	begin
		sclPrev <= scl;
		sdaPrev <= sda;
		if (!PRESETn)
		begin
			pull <= 1'b0;
			active <= 1'b0;
			addrPhase <= 1'b0;
			selected <= 1'b0;
			readMode <= 1'b0;
			masterAcked <= 1'b0;
			bitCnt <= 4'd0;
			readIdx <= 8'd0;
			capCount <= 0;
		end
		else if (sclPrev && scl && sdaPrev && !sda)
		begin
			// START, SDA falls with SCL high
			active <= 1'b1;
			addrPhase <= 1'b1;
			selected <= 1'b0;
			bitCnt <= 4'd0;
			readIdx <= 8'd0;
			pull <= 1'b0;
		end
		else if (sclPrev && scl && !sdaPrev && sda)
		begin
			// STOP, SDA rises with SCL high
			active <= 1'b0;
			pull <= 1'b0;
		end
		else if (active && !sclPrev && scl)
		begin
			// Rising SCL, data is valid
			if (bitCnt < 4'd8)
			begin
				shiftIn <= {shiftIn[6:0], sda};
			end
			else
			begin
				masterAcked <= !sda;
			end
			bitCnt <= bitCnt + 4'd1;
		end
		else if (active && sclPrev && !scl)
		begin
			////////////////////
			// Falling SCL
			////////////////////
			if (bitCnt == 4'd8)
			begin
				if (addrPhase)
				begin
					// Only the own address gets an ACK
					selected <= (shiftIn[7:1] == ownAddr);
					readMode <= shiftIn[0];
					pull <= (shiftIn[7:1] == ownAddr);
				end
				else if (selected && !readMode)
				begin
					capData.push_back(shiftIn);
					capCount <= capCount + 1;
					pull <= 1'b1;
				end
				else
				begin
					// Release for the master ACK slot
					pull <= 1'b0;
				end
			end
			else if (bitCnt == 4'd9)
			begin
				bitCnt <= 4'd0;
				addrPhase <= 1'b0;
				if (selected && readMode && (addrPhase || masterAcked))
				begin
					// Next reply byte, MSB goes out first
					pull <= !replyByte[7];
					shiftOut <= {replyByte[6:0], 1'b0};
					readIdx <= readIdx + 8'd1;
				end
				else
				begin
					pull <= 1'b0;
					// Master NACK ends the reply stream
					selected <= selected && !readMode;
				end
			end
			else if (bitCnt != 4'd0 && selected && readMode && !addrPhase)
			begin
				pull <= !shiftOut[7];
				shiftOut <= {shiftOut[6:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/apbI2cTb.sv
// Testbench for the APB I2C master with directed register, transfer, NACK and credit tests
`default_nettype none
`timescale 1ns/1ps

module apbI2cTb;
	import apbRegPkg::*;
	import i2cBusPkg::*;

	localparam int fifoDepth = 4;
	localparam int halfClkNs = 50;
	localparam i2cAddrT targetAddr = 7'h2A;
	localparam i2cAddrT badAddr = 7'h15;
	localparam logic [31:0] clkDivValue = 32'd4;
	localparam logic [31:0] regMask = 32'((1 << cfgWidth) - 1);
	// Five short transfers at a divider of 4 plus polling stay near 2500 cycles
	localparam int maxCycles = 20000;

	logic PCLK;
	logic PRESETn;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [31:0] pAddr;
	logic [31:0] pWdata;
	logic [31:0] pRdata;
	logic pReady;
	logic pSlvErr;
	logic scl;
	logic sdaOe;
	logic sdaLine;
	logic intTx;
	logic intRx;

	int errors;
	int testCount;
	int cycleCount = 0;
	logic [15:0] lfsr;
	logic [7:0] sentBytes [$];
	// Results of the last APB access
	logic [31:0] lastRdata;
	logic lastErr;
	int lastStalls;

	apbI2cTop #(.fifoDepth(fifoDepth)) i_apbI2cTop (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata),
		.pRdata(pRdata), .pReady(pReady), .pSlvErr(pSlvErr),
		.scl(scl), .sdaOe(sdaOe), .sdaIn(sdaLine),
		.intTx(intTx), .intRx(intRx)
	);

	i2cTargetModel #(.ownAddr(targetAddr)) target (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.scl(scl), .masterPull(sdaOe), .sda(sdaLine)
	);

	always #halfClkNs PCLK = ~PCLK;

	// Run limit
	always @(posedge PCLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= maxCycles)
		begin
			$display("Timeout after %0d cycles, a transfer or access never completed", cycleCount);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		errors++;
		$display("Error: %s expected 0x%08h got 0x%08h at %0t", name, expected, got, $time);
	endtask

	task automatic logFailure(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// One LFSR step per data bit
	task automatic nextRandomByte(output logic [7:0] value);
		value = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrNext(lfsr);
			value = {value[6:0], lfsr[0]};
		end
	endtask

	// Configuration word with the start bit set
	function automatic logic [31:0] cfgValue(input logic read, input i2cAddrT addr,
		input int count);
		return (32'(count) << cfgCountLsb) | (32'(addr) << cfgAddrLsb)
			| (32'(read) << cfgReadBit) | (32'h1 << cfgStartBit);
	endfunction

	// Setup and access phases followed by a hold until pReady
	task automatic busAccess(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata);
		@(posedge PCLK);
		#1;
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWdata = wdata;
		@(posedge PCLK);
		#1;
		pEnable = 1'b1;
		lastStalls = 0;
		@(posedge PCLK);
		while (!pReady)
		begin
			lastStalls++;
			@(posedge PCLK);
		end
		lastRdata = pRdata;
		lastErr = pSlvErr;
		#1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
		busAccess(1'b1, addr, data);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data,
		output logic err);
		busAccess(1'b0, addr, 32'h0);
		data = lastRdata;
		err = lastErr;
	endtask

	// Poll the start bit until the transaction is over
	task automatic waitXferDone(output logic errSeen);
		logic [31:0] data;
		logic err;
		errSeen = 1'b0;
		data = 32'h1;
		while (data[cfgStartBit])
		begin
			apbRead(regAddrConfig, data, err);
			errSeen = errSeen | err;
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic resetDefaults();
		logic [31:0] addrs [3] = '{regAddrConfig, regAddrClkDiv, regAddrRxCredits};
		logic [31:0] data;
		logic err;
		testCount++;
		if (pReady !== 1'b0) reportMismatch("pReady", 32'(pReady), 32'h0);
		if (pSlvErr !== 1'b0) reportMismatch("pSlvErr", 32'(pSlvErr), 32'h0);
		if (intTx !== 1'b1) reportMismatch("intTx", 32'(intTx), 32'h1);
		if (intRx !== 1'b0) reportMismatch("intRx", 32'(intRx), 32'h0);
		if (scl !== 1'b1) reportMismatch("scl", 32'(scl), 32'h1);
		if (sdaOe !== 1'b0) reportMismatch("sdaOe", 32'(sdaOe), 32'h0);
		for (int i = 0; i < 3; i++)
		begin
			apbRead(addrs[i], data, err);
			if (data !== 32'h0) reportMismatch("pRdata", data, 32'h0);
			if (err !== 1'b0) reportMismatch("pSlvErr", 32'(err), 32'h0);
		end
	endtask

	task automatic registerReadback();
		logic [31:0] cfgSample;
		logic [31:0] divSample;
		logic [31:0] data;
		logic err;
		testCount++;
		// Start bit clear so nothing launches
		cfgSample = 32'hFFFF_5A5A;
		divSample = 32'hC0DE_7ABC;
		apbWrite(regAddrConfig, cfgSample);
		apbRead(regAddrConfig, data, err);
		if (data !== (cfgSample & regMask)) reportMismatch("pRdata", data, cfgSample & regMask);
		apbWrite(regAddrClkDiv, divSample);
		apbRead(regAddrClkDiv, data, err);
		if (data !== (divSample & regMask)) reportMismatch("pRdata", data, divSample & regMask);
		apbWrite(regAddrConfig, 32'h0);
		apbWrite(regAddrClkDiv, clkDivValue);
	endtask

	task automatic writeTransaction();
		logic [7:0] value;
		logic errSeen;
		int capBase;
		testCount++;
		capBase = target.capCount;
		sentBytes.delete();
		for (int i = 0; i < 3; i++)
		begin
			nextRandomByte(value);
			sentBytes.push_back(value);
			apbWrite(regAddrTx, 32'(value));
		end
		// Transmit FIFO now holds data
		if (intTx !== 1'b0) reportMismatch("intTx", 32'(intTx), 32'h0);
		apbWrite(regAddrConfig, cfgValue(1'b0, targetAddr, 3));
		waitXferDone(errSeen);
		if (errSeen) logFailure("pSlvErr went high during a write the target acknowledged");
		if (target.capCount != capBase + 3)
			reportMismatch("capture count", 32'(target.capCount - capBase), 32'd3);
		for (int i = 0; i < 3; i++)
		begin
			if (target.capData[capBase + i] !== sentBytes[i])
				reportMismatch("target byte", 32'(target.capData[capBase + i]), 32'(sentBytes[i]));
		end
		if (intTx !== 1'b1) reportMismatch("intTx", 32'(intTx), 32'h1);
	endtask

	task automatic readTransaction();
		logic [31:0] data;
		logic err;
		logic errSeen;
		testCount++;
		apbWrite(regAddrConfig, cfgValue(1'b1, targetAddr, 4));
		waitXferDone(errSeen);
		apbRead(regAddrRxCredits, data, err);
		if (data !== 32'd4) reportMismatch("pRdata", data, 32'd4);
		if (intRx !== 1'b1) reportMismatch("intRx", 32'(intRx), 32'h1);
		// Target replies count up from 0xA0
		for (int i = 0; i < 4; i++)
		begin
			apbRead(regAddrRx, data, err);
			if (data !== 32'hA0 + 32'(i)) reportMismatch("pRdata", data, 32'hA0 + 32'(i));
		end
		if (intRx !== 1'b0) reportMismatch("intRx", 32'(intRx), 32'h0);
	endtask

	task automatic nackRecovery();
		logic [31:0] data;
		logic [7:0] value;
		logic err;
		logic errSeen;
		int capBase;
		testCount++;
		capBase = target.capCount;
		apbWrite(regAddrConfig, cfgValue(1'b0, badAddr, 1));
		waitXferDone(errSeen);
		if (target.capCount != capBase)
			reportMismatch("capture count", 32'(target.capCount - capBase), 32'd0);
		apbRead(regAddrClkDiv, data, err);
		if (err !== 1'b1) reportMismatch("pSlvErr", 32'(err), 32'h1);
		// A good transfer clears the sticky error
		nextRandomByte(value);
		apbWrite(regAddrTx, 32'(value));
		apbWrite(regAddrConfig, cfgValue(1'b0, targetAddr, 1));
		waitXferDone(errSeen);
		apbRead(regAddrClkDiv, data, err);
		if (err !== 1'b0) reportMismatch("pSlvErr", 32'(err), 32'h0);
		if (target.capData[capBase] !== value)
			reportMismatch("target byte", 32'(target.capData[capBase]), 32'(value));
	endtask

	task automatic creditBackPressure();
		logic [7:0] value;
		logic errSeen;
		int capBase;
		testCount++;
		capBase = target.capCount;
		sentBytes.delete();
		// Four pushes use up every credit
		for (int i = 0; i < 4; i++)
		begin
			nextRandomByte(value);
			sentBytes.push_back(value);
			apbWrite(regAddrTx, 32'(value));
			if (lastStalls != 0) logFailure("a push with free credits was held off");
		end
		apbWrite(regAddrConfig, cfgValue(1'b0, targetAddr, 1));
		// Fifth push waits for the first pop of the transfer
		nextRandomByte(value);
		apbWrite(regAddrTx, 32'(value));
		if (lastStalls < 10) logFailure("the push without a credit was not held for ten cycles");
		waitXferDone(errSeen);
		if (target.capCount != capBase + 1)
			reportMismatch("capture count", 32'(target.capCount - capBase), 32'd1);
		if (target.capData[capBase] !== sentBytes[0])
			reportMismatch("target byte", 32'(target.capData[capBase]), 32'(sentBytes[0]));
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial
	begin
		PCLK = 1'b0;
		PRESETn = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = 32'h0;
		pWdata = 32'h0;
		lfsr = 16'd42;
		errors = 0;
		testCount = 0;
		repeat (8) @(posedge PCLK);
		#1;
		PRESETn = 1'b1;
		resetDefaults();
		registerReadback();
		writeTransaction();
		readTransaction();
		nackRecovery();
		creditBackPressure();
		$display("Summary: %0d tests run, %0d errors", testCount, errors);
		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/apbRegPkg.sv
logic/i2cBusPkg.sv
logic/byteFifo.sv
logic/apbSlave.sv
logic/i2cMaster.sv
logic/apbI2cTop.sv
verification/i2cTargetModel.sv
verification/apbI2cTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the APB I2C testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module apbI2cTb -f sources.f -o apbI2cSim
./obj_dir/apbI2cSim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
